/* clmul_coeff_combine.sv */
// Coefficient combiner of the carry-less multiplier.
// Folds the sixteen limb products into seven coefficient groups, places them
// at limb offsets in the product register and pulses done one cycle after fold.

`timescale 1ns/1ps

module clmul_coeff_combine (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         fold,
	input  logic [clmul_pkg::LIMB_N*clmul_pkg::LIMB_N*clmul_pkg::PART_W-1:0] parts,
	output logic [clmul_pkg::PROD_W-1:0] c,
	output logic                         done
);
	import clmul_pkg::*;

	// Coefficient k collects every pair whose limb indices sum to k
	logic [PART_W-1:0] coeff [COEFF_N];

	// Coefficients shifted into place and merged
	logic [PROD_W-1:0] placed;

	always_comb begin
		for (int k = 0; k < COEFF_N; k++) begin
			coeff[k] = '0;
		end
		for (int i = 0; i < LIMB_N; i++) begin
			for (int j = 0; j < LIMB_N; j++) begin
				coeff[i + j] = coeff[i + j] ^ parts[(i*LIMB_N + j)*PART_W +: PART_W];
			end
		end
	end

	// Neighbouring coefficients overlap by LIMB_W bits, hence XOR, not OR
	always_comb begin
		placed = '0;
		for (int k = 0; k < COEFF_N; k++) begin
			placed = placed ^ (PROD_W'(coeff[k]) << (k * LIMB_W));
		end
	end

	// c holds until the next fold, so a new start leaves it untouched
	always_ff @(posedge clk) begin
		if (rst) begin
			c <= '0;
			done <= 1'b0;
		end else begin
			done <= fold;
			if (fold) begin
				c <= placed;
			end
		end
	end

endmodule

/* clmul_operand_seq.sv */
// Operand sequencer of the carry-less multiplier.
// Captures a and b on an accepted start, then walks the limb bits out to the
// partial-product bank for LIMB_W cycles and raises fold for one cycle.

`timescale 1ns/1ps

module clmul_operand_seq (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            start,
	input  logic [clmul_pkg::OPERAND_W-1:0] a,
	input  logic [clmul_pkg::OPERAND_W-1:0] b,
	output logic                            busy,
	output logic                            clear,
	output logic                            step_en,
	output logic                            fold,
	output logic [clmul_pkg::LIMB_N-1:0]    a_bits,
	output logic [clmul_pkg::OPERAND_W-1:0] b_limbs,
	output logic [clmul_pkg::STEP_W-1:0]    step_idx
);
	import clmul_pkg::*;

	seq_state_t state;

	// Captured operands, a is shifted right once per step
	logic [OPERAND_W-1:0] a_sh;
	logic [OPERAND_W-1:0] b_hold;

	logic [STEP_W-1:0] step_cnt;
	logic              accept;
	logic              last_step;

	// Start only counts while idle, which includes the done cycle
	assign accept = start && (state == st_idle);
	assign last_step = (step_cnt == STEP_W'(LIMB_W - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			step_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_run;
						step_cnt <= '0;
					end
				end
				st_run: begin
					step_cnt <= step_cnt + STEP_W'(1);
					if (last_step) begin
						state <= st_fold;
					end
				end
				st_fold: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// The whole vector shifts as one. Bits from the limb above enter at the
	// top of each limb and need LIMB_W shifts to reach its bit 0, so limb
	// bit 0 shows bit step_cnt of the original limb for every run step
	always_ff @(posedge clk) begin
		if (accept) begin
			a_sh <= a;
			b_hold <= b;
		end else if (state == st_run) begin
			a_sh <= a_sh >> 1;
		end
	end

	always_comb begin
		for (int i = 0; i < LIMB_N; i++) begin
			a_bits[i] = a_sh[i * LIMB_W];
		end
	end

	assign b_limbs = b_hold;
	assign step_idx = step_cnt;

	// Bank zeroes its accumulators on the accepting edge itself
	assign clear = accept;
	assign step_en = (state == st_run);
	assign fold = (state == st_fold);
	assign busy = (state != st_idle);

endmodule

/* clmul_partial_bank.sv */
// Partial-product bank of the carry-less multiplier.
// Sixteen shift-and-XOR accumulators, one per (a limb, b limb) pair, all
// stepped by the sequencer's shared bit counter.

`timescale 1ns/1ps

module clmul_partial_bank (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            clear,
	input  logic                            step_en,
	input  logic [clmul_pkg::LIMB_N-1:0]    a_bits,
	input  logic [clmul_pkg::OPERAND_W-1:0] b_limbs,
	input  logic [clmul_pkg::STEP_W-1:0]    step_idx,
	output logic [clmul_pkg::LIMB_N*clmul_pkg::LIMB_N*clmul_pkg::PART_W-1:0] parts
);
	import clmul_pkg::*;

	// Each b limb zero-extended to the partial width before shifting
	logic [PART_W-1:0] b_wide [LIMB_N];

	genvar i;
	genvar j;

	generate
		for (j = 0; j < LIMB_N; j++) begin : g_b_wide
			assign b_wide[j] = {{(PART_W - LIMB_W){1'b0}}, b_limbs[j*LIMB_W +: LIMB_W]};
		end
	endgenerate

	// Row i takes its enable from bit i of a_bits, column j its addend
	// from b limb j. Output slot is i*LIMB_N + j
	generate
		for (i = 0; i < LIMB_N; i++) begin : g_row
			for (j = 0; j < LIMB_N; j++) begin : g_col
				logic [PART_W-1:0] acc;
				logic              hit;

				assign hit = step_en && a_bits[i];

				always_ff @(posedge clk) begin
					if (rst || clear) begin
						acc <= '0;
					end else if (hit) begin
						// step_idx tops out at LIMB_W-1 so nothing falls off
						acc <= acc ^ (b_wide[j] << step_idx);
					end
				end

				assign parts[(i*LIMB_N + j)*PART_W +: PART_W] = acc;
			end
		end
	endgenerate

endmodule

/* clmul_pkg.sv */
// Shared widths and the sequencer state type for the carry-less multiplier.
// Import into any module that builds on the four-way limb split.

package clmul_pkg;

	// Operand size and the four-way limb split
	localparam int OPERAND_W = 64;
	localparam int LIMB_N = 4;
	localparam int LIMB_W = OPERAND_W / LIMB_N;

	// A 16x16 carry-less product needs only 31 bits, so the top bit stays clear
	localparam int PART_W = 2 * LIMB_W;

	// Full product width
	localparam int PROD_W = 2 * OPERAND_W;

	// Limb index sums run from 0 to 2*(LIMB_N-1)
	localparam int COEFF_N = 2 * LIMB_N - 1;

	// Counts bit positions 0 to LIMB_W, one extra bit of headroom
	localparam int STEP_W = 5;

	// Sequencer states
	// st_idle waits for start
	// st_run walks the LIMB_W accumulate steps
	// st_fold is the single cycle that hands the partials to the combiner
	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_fold
	} seq_state_t;

endpackage

/* clmul_top.sv */
// Top level of the 64x64 carry-less (GF(2) polynomial) multiplier.
// Pulse start while busy is low; c is valid and held from the done pulse,
// 18 cycles after the accepting edge, until the next result.

`timescale 1ns/1ps

module clmul_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            start,
	input  logic [clmul_pkg::OPERAND_W-1:0] a,
	input  logic [clmul_pkg::OPERAND_W-1:0] b,
	output logic                            busy,
	output logic                            done,
	output logic [clmul_pkg::PROD_W-1:0]    c
);
	import clmul_pkg::*;

	// Sequencer to bank
	logic                 clear;
	logic                 step_en;
	logic [LIMB_N-1:0]    a_bits;
	logic [OPERAND_W-1:0] b_limbs;
	logic [STEP_W-1:0]    step_idx;

	// Sequencer to combiner
	logic fold;

	// Bank to combiner, pair (i, j) at slot i*LIMB_N + j
	logic [LIMB_N*LIMB_N*PART_W-1:0] parts;

	clmul_operand_seq clmul_operand_seq_inst (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.a        (a),
		.b        (b),
		.busy     (busy),
		.clear    (clear),
		.step_en  (step_en),
		.fold     (fold),
		.a_bits   (a_bits),
		.b_limbs  (b_limbs),
		.step_idx (step_idx)
	);

	clmul_partial_bank clmul_partial_bank_inst (
		.clk      (clk),
		.rst      (rst),
		.clear    (clear),
		.step_en  (step_en),
		.a_bits   (a_bits),
		.b_limbs  (b_limbs),
		.step_idx (step_idx),
		.parts    (parts)
	);

	clmul_coeff_combine clmul_coeff_combine_inst (
		.clk      (clk),
		.rst      (rst),
		.fold     (fold),
		.parts    (parts),
		.c        (c),
		.done     (done)
	);

endmodule

/* files.f */
clmul_pkg.sv
clmul_operand_seq.sv
clmul_partial_bank.sv
clmul_coeff_combine.sv
clmul_top.sv
tb_clmul.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the carry-less multiplier testbench with Verilator and runs it.
# Exit status is nonzero when the log reports a failure or lacks the pass line.

set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"
rm -f "$LOG"

verilator --binary --assert -Wno-fatal \
	-f files.f \
	--top-module tb_clmul \
	-Mdir "$BUILD_DIR"

# tee keeps the pipeline status so the log check below decides the result
"./$BUILD_DIR/Vtb_clmul" 2>&1 | tee "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi

exit 0

/* tb_clmul.sv */
// Self-checking testbench for the 64x64 carry-less multiplier.
// Drives directed, random, busy-start, back-to-back, hold and mid-run reset cases
// and checks c and the done timing against a bitwise reference model.

`timescale 1ns/1ps

module tb_clmul;
	import clmul_pkg::*;

	localparam int DONE_LAT = 18;
	localparam int OP_COUNT = 312;
	localparam int WATCHDOG_CYCLES = OP_COUNT * 20 + 200;

	logic                 clk;
	logic                 rst;
	logic                 start;
	logic [OPERAND_W-1:0] a;
	logic [OPERAND_W-1:0] b;
	logic                 busy;
	logic                 done;
	logic [PROD_W-1:0]    c;

	integer seed;
	int     cyc;

	// Accepted operations still waiting for done in order of acceptance
	logic [OPERAND_W-1:0] q_a [$];
	logic [OPERAND_W-1:0] q_b [$];
	int                   q_acc [$];

	logic [PROD_W-1:0]    held_c;
	logic [PROD_W-1:0]    exp_c;
	logic [OPERAND_W-1:0] cur_a;
	logic [OPERAND_W-1:0] cur_b;
	int                   cur_acc;

	clmul_top clmul_top_inst (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.a     (a),
		.b     (b),
		.busy  (busy),
		.done  (done),
		.c     (c)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Shift-and-XOR over every set bit of x
	function automatic logic [PROD_W-1:0] clmul_ref(input logic [OPERAND_W-1:0] x,
			input logic [OPERAND_W-1:0] y);
		logic [PROD_W-1:0] res;
		res = '0;
		for (int i = 0; i < OPERAND_W; i++) begin
			if (x[i])
				res = res ^ ({{OPERAND_W{1'b0}}, y} << i);
		end
		return res;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic value_mismatch(input string sig, input logic [PROD_W-1:0] got,
			input logic [PROD_W-1:0] expv);
		abort_run($sformatf("Fail at time %0t: %s got %h expected %h", $time, sig, got, expv));
	endtask

	// Called at a falling edge and waits for idle before a one-cycle start pulse
	task automatic issue(input logic [OPERAND_W-1:0] av, input logic [OPERAND_W-1:0] bv);
		while (busy)
			@(negedge clk);
		a = av;
		b = bv;
		start = 1'b1;
		q_a.push_back(av);
		q_b.push_back(bv);
		q_acc.push_back(cyc + 1);
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic drain();
		while (q_acc.size() != 0 || busy)
			@(negedge clk);
	endtask

	task automatic random_operands(output logic [OPERAND_W-1:0] ra,
			output logic [OPERAND_W-1:0] rb);
		ra = {$random(seed), $random(seed)};
		rb = {$random(seed), $random(seed)};
	endtask

	// Compare process samples DUT outputs on the rising edge
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (rst) begin
			held_c = '0;
		end else begin
			if (q_acc.size() == 0) begin
				assert (!busy) else abort_run("busy is high with no operation pending");
			end else if (cyc > q_acc[0] && cyc < q_acc[0] + DONE_LAT) begin
				assert (busy) else abort_run("busy dropped before the result was ready");
			end
			if (done) begin
				assert (q_acc.size() != 0) else abort_run("done pulsed with no operation pending");
				cur_a = q_a.pop_front();
				cur_b = q_b.pop_front();
				cur_acc = q_acc.pop_front();
				assert (cyc - cur_acc == DONE_LAT)
					else value_mismatch("done latency", cyc - cur_acc, DONE_LAT);
				exp_c = clmul_ref(cur_a, cur_b);
				assert (c == exp_c) else value_mismatch("c", c, exp_c);
				held_c = c;
			end else begin
				if (q_acc.size() != 0) begin
					assert (cyc - q_acc[0] < DONE_LAT)
						else abort_run("done did not arrive 18 cycles after start");
				end
				assert (c == held_c) else value_mismatch("c", c, held_c);
			end
		end
	end

	// Watchdog sized from the number of operations
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired, the DUT appears to hang");
	end

	initial begin
		logic [OPERAND_W-1:0] ra;
		logic [OPERAND_W-1:0] rb;
		seed = 28459;
		cyc = 0;
		held_c = '0;
		rst = 1'b1;
		start = 1'b0;
		a = '0;
		b = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		assert (!busy && !done) else abort_run("busy or done high after reset");
		assert (c == '0) else value_mismatch("c", c, '0);

		// Reference sanity for the top product bit
		assert (clmul_ref(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000) == (128'd1 << 126))
			else abort_run("reference model is wrong for the top bit");

		// Directed cases
		issue(64'h0, 64'hdead_beef_0123_4567);
		issue(64'h89ab_cdef_fedc_ba98, 64'h0);
		issue(64'h1, 64'hcafe_f00d_1357_9bdf);
		issue(64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
		issue(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
		drain();

		// Random operands issued back to back
		for (int n = 0; n < 300; n++) begin
			random_operands(ra, rb);
			issue(ra, rb);
		end
		drain();

		// Start while busy must be ignored
		random_operands(ra, rb);
		issue(ra, rb);
		repeat (3) @(negedge clk);
		assert (busy) else abort_run("busy low during a running operation");
		random_operands(ra, rb);
		a = ra;
		b = rb;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		drain();
		repeat (25) @(negedge clk);

		// Second start lands in the done cycle of the first
		random_operands(ra, rb);
		issue(ra, rb);
		while (!done)
			@(negedge clk);
		assert (!busy) else abort_run("busy still high in the done cycle");
		random_operands(ra, rb);
		issue(ra, rb);
		drain();

		// c holds while the inputs wander and during the next run
		random_operands(ra, rb);
		issue(ra, rb);
		drain();
		for (int n = 0; n < 20; n++) begin
			random_operands(ra, rb);
			a = ra;
			b = rb;
			@(negedge clk);
		end
		random_operands(ra, rb);
		issue(ra, rb);
		drain();

		// Reset in the middle of a run and no done may follow
		random_operands(ra, rb);
		issue(ra, rb);
		repeat (8) @(negedge clk);
		rst = 1'b1;
		q_a.delete();
		q_b.delete();
		q_acc.delete();
		repeat (3) @(negedge clk);
		rst = 1'b0;
		repeat (30) @(negedge clk);
		assert (!busy) else abort_run("busy high after reset in the middle of a run");
		random_operands(ra, rb);
		issue(ra, rb);
		drain();

		repeat (20) @(negedge clk);
		if (q_acc.size() == 0 && !busy) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			abort_run("operations left without a result at the end of the run");
		end
	end

endmodule
